// File: hdl/cpu_pkg.sv
package cpu_pkg;

    // Architectural word width.
    localparam int XLEN = 32;

    // Number of integer registers.
    localparam int REG_NUM = 32;

    // Data and address word.
    typedef logic [XLEN-1:0] u32_t;

    // Architectural register index.
    typedef logic [$clog2(REG_NUM)-1:0] reg_idx_t;

    // Load access width.
    typedef enum logic [1:0] {
        LD_BYTE = 2'd0,
        LD_HALF = 2'd1,
        LD_WORD = 2'd2
    } ld_size_t;

endpackage

// File: hdl/mem2_stage.sv
`timescale 1ns/1ps

module mem2_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    // Pipeline control.
    input  logic     flush,
    input  logic     next_rdy_in,
    output logic     rdy_in,

    // From the first memory stage.
    input  logic     valid_in,
    input  logic     is_ld,
    input  logic     ld_unsigned,
    input  logic     is_wr_rd,
    input  logic     is_wr_rd_pc_plus4,
    input  ld_size_t ld_size,
    input  u32_t     pc_in,
    input  u32_t     ex_out,
    input  u32_t     mem_rdata,
    input  reg_idx_t rd_in,

    // To writeback.
    output logic     valid,
    output logic     wr_rd,
    output logic     wr_pc_plus4,
    output u32_t     pc,
    output u32_t     result,
    output reg_idx_t rd
);

    logic     valid_r;
    logic     is_ld_r;
    logic     ld_unsigned_r;
    ld_size_t ld_size_r;
    u32_t     ex_out_r;
    u32_t     mem_rdata_r;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rdy_in = flush | ~valid_r | next_rdy_in;

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            valid_r <= 1'b0;
        end else if (rdy_in) begin
            // A flush also kills the item arriving on the same edge.
            valid_r <= valid_in & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy_in) begin
            is_ld_r       <= is_ld;
            ld_unsigned_r <= ld_unsigned;
            ld_size_r     <= ld_size;
            wr_rd         <= is_wr_rd;
            wr_pc_plus4   <= is_wr_rd_pc_plus4;
            pc            <= pc_in;
            ex_out_r      <= ex_out;
            mem_rdata_r   <= mem_rdata;
            rd            <= rd_in;
        end
    end

    assign valid = valid_r & ~flush;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load data extraction.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [1:0]  ofs;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    u32_t        ld_data;

    assign ofs = ex_out_r[1:0];

    always_comb begin
        case (ofs)
            2'd0:    ld_byte = mem_rdata_r[7:0];
            2'd1:    ld_byte = mem_rdata_r[15:8];
            2'd2:    ld_byte = mem_rdata_r[23:16];
            default: ld_byte = mem_rdata_r[31:24];
        endcase
    end

    assign ld_half = ofs[1] ? mem_rdata_r[31:16] : mem_rdata_r[15:0];

    always_comb begin
        case (ld_size_r)
            LD_BYTE: ld_data = {{24{~ld_unsigned_r & ld_byte[7]}}, ld_byte};
            LD_HALF: ld_data = {{16{~ld_unsigned_r & ld_half[15]}}, ld_half};
            default: ld_data = mem_rdata_r;
        endcase
    end

    assign result = is_ld_r ? ld_data : ex_out_r;

    // Misaligned half and word loads never reach this stage.
    a_ld_align: assert property (
        @(posedge clk) disable iff (~rst_n)
        valid_r && is_ld_r |->
            (ld_size_r != LD_HALF || ofs[0] == 1'b0) &&
            (ld_size_r != LD_WORD || ofs == 2'd0)
    );

endmodule

// File: hdl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    // Pipeline control.
    input  logic     flush,
    input  logic     next_rdy_in,
    output logic     rdy_in,
    output logic     retire,

    // From the second memory stage.
    input  logic     valid_in,
    input  logic     wr_rd_in,
    input  logic     wr_pc_plus4_in,
    input  u32_t     pc_in,
    input  u32_t     result_in,
    input  reg_idx_t rd_in,

    // To the register file.
    output logic     reg_we,
    output reg_idx_t reg_idx,
    output u32_t     reg_data,
    output u32_t     pc
);

    logic valid_r;
    logic wr_rd_r;
    logic wr_pc_plus4_r;
    u32_t result_r;
    logic wb_flush;
    logic wb_stall;

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            valid_r <= 1'b0;
        end else if (rdy_in) begin
            valid_r <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy_in) begin
            wr_rd_r       <= wr_rd_in;
            wr_pc_plus4_r <= wr_pc_plus4_in;
            pc            <= pc_in;
            result_r      <= result_in;
            reg_idx       <= rd_in;
        end
    end

    assign wb_flush = flush | ~valid_r;
    assign wb_stall = ~next_rdy_in;

    assign rdy_in = wb_flush | ~wb_stall;
    assign retire = ~wb_flush & ~wb_stall;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register write.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign reg_we   = ~wb_flush & wr_rd_r;
    assign reg_data = wr_pc_plus4_r ? pc + 32'd4 : result_r;

    a_retire_rdy: assert property (
        @(posedge clk) disable iff (~rst_n)
        retire |-> rdy_in
    );

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    // Write port.
    input  logic     we,
    input  reg_idx_t widx,
    input  u32_t     wdata,

    // Read ports.
    input  reg_idx_t ridx_a,
    input  reg_idx_t ridx_b,
    output u32_t     rdata_a,
    output u32_t     rdata_b
);

    u32_t regs [REG_NUM];

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && widx != '0) begin
            regs[widx] <= wdata;
        end
    end

    // A same-cycle write is seen one cycle later.
    assign rdata_a = (ridx_a == '0) ? '0 : regs[ridx_a];
    assign rdata_b = (ridx_b == '0) ? '0 : regs[ridx_b];

endmodule

// File: hdl/commit_trace.sv
`timescale 1ns/1ps

module commit_trace import cpu_pkg::*; #(
    parameter int CNT_W = 32
) (
    input  logic             clk,
    input  logic             rst_n,

    // From writeback.
    input  logic             retire,
    input  logic             wen,
    input  reg_idx_t         wdest,
    input  u32_t             wdata,
    input  u32_t             pc_in,

    // Commit record.
    output logic             commit_valid,
    output logic             commit_wen,
    output reg_idx_t         commit_wdest,
    output u32_t             commit_wdata,
    output u32_t             commit_pc,
    output logic [CNT_W-1:0] retired_count
);

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            commit_valid  <= 1'b0;
            commit_wen    <= 1'b0;
            retired_count <= '0;
        end else begin
            commit_valid <= retire;
            // Writes to r0 are not architectural.
            commit_wen   <= retire & wen & (wdest != '0);
            if (retire) begin
                retired_count <= retired_count + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_wdest <= wdest;
            commit_wdata <= wdata;
            commit_pc    <= pc_in;
        end
    end

endmodule

// File: hdl/backend_top.sv
`timescale 1ns/1ps

module backend_top import cpu_pkg::*; #(
    parameter int CNT_W = 32
) (
    input  logic             clk,
    input  logic             rst_n,

    // From the first memory stage.
    input  logic             flush,
    input  logic             valid_in,
    input  logic             is_ld,
    input  logic             ld_unsigned,
    input  logic             is_wr_rd,
    input  logic             is_wr_rd_pc_plus4,
    input  ld_size_t         ld_size,
    input  u32_t             pc_in,
    input  u32_t             ex_out,
    input  u32_t             mem_rdata,
    input  reg_idx_t         rd_in,
    output logic             rdy_in,

    // Trace consumer.
    input  logic             retire_rdy,

    // Register read ports.
    input  reg_idx_t         ridx_a,
    input  reg_idx_t         ridx_b,
    output u32_t             rdata_a,
    output u32_t             rdata_b,

    // Commit record.
    output logic             commit_valid,
    output logic             commit_wen,
    output reg_idx_t         commit_wdest,
    output u32_t             commit_wdata,
    output u32_t             commit_pc,
    output logic [CNT_W-1:0] retired_count
);

    logic     m2_valid;
    logic     m2_wr_rd;
    logic     m2_wr_pc_plus4;
    u32_t     m2_pc;
    u32_t     m2_result;
    reg_idx_t m2_rd;

    logic     wb_rdy_in;
    logic     wb_retire;
    logic     reg_we;
    reg_idx_t reg_idx;
    u32_t     reg_data;
    u32_t     wb_pc;

    mem2_stage u_mem2 (
        .clk               (clk),
        .rst_n             (rst_n),
        .flush             (flush),
        .next_rdy_in       (wb_rdy_in),
        .rdy_in            (rdy_in),
        .valid_in          (valid_in),
        .is_ld             (is_ld),
        .ld_unsigned       (ld_unsigned),
        .is_wr_rd          (is_wr_rd),
        .is_wr_rd_pc_plus4 (is_wr_rd_pc_plus4),
        .ld_size           (ld_size),
        .pc_in             (pc_in),
        .ex_out            (ex_out),
        .mem_rdata         (mem_rdata),
        .rd_in             (rd_in),
        .valid             (m2_valid),
        .wr_rd             (m2_wr_rd),
        .wr_pc_plus4       (m2_wr_pc_plus4),
        .pc                (m2_pc),
        .result            (m2_result),
        .rd                (m2_rd)
    );

    writeback_stage u_wb (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .next_rdy_in    (retire_rdy),
        .rdy_in         (wb_rdy_in),
        .retire         (wb_retire),
        .valid_in       (m2_valid),
        .wr_rd_in       (m2_wr_rd),
        .wr_pc_plus4_in (m2_wr_pc_plus4),
        .pc_in          (m2_pc),
        .result_in      (m2_result),
        .rd_in          (m2_rd),
        .reg_we         (reg_we),
        .reg_idx        (reg_idx),
        .reg_data       (reg_data),
        .pc             (wb_pc)
    );

    reg_file u_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (reg_we),
        .widx    (reg_idx),
        .wdata   (reg_data),
        .ridx_a  (ridx_a),
        .ridx_b  (ridx_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    commit_trace #(
        .CNT_W (CNT_W)
    ) u_trace (
        .clk           (clk),
        .rst_n         (rst_n),
        .retire        (wb_retire),
        .wen           (reg_we),
        .wdest         (reg_idx),
        .wdata         (reg_data),
        .pc_in         (wb_pc),
        .commit_valid  (commit_valid),
        .commit_wen    (commit_wen),
        .commit_wdest  (commit_wdest),
        .commit_wdata  (commit_wdata),
        .commit_pc     (commit_pc),
        .retired_count (retired_count)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period.
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: sim/tb_backend.sv
`timescale 1ns/1ps

module tb_backend import cpu_pkg::*; ();

    localparam int CNT_W = 32;

    // One expected commit record.
    typedef struct packed {
        u32_t     pc;
        reg_idx_t dest;
        logic     wen;
        u32_t     data;
    } commit_t;

    logic             clk;
    logic             rst_n;
    logic             flush;
    logic             valid_in;
    logic             rdy_in;
    logic             retire_rdy;
    logic             is_ld;
    logic             ld_unsigned;
    logic             is_wr_rd;
    logic             is_wr_rd_pc_plus4;
    ld_size_t         ld_size;
    u32_t             pc_in;
    u32_t             ex_out;
    u32_t             mem_rdata;
    reg_idx_t         rd_in;
    reg_idx_t         ridx_a;
    reg_idx_t         ridx_b;
    u32_t             rdata_a;
    u32_t             rdata_b;
    logic             commit_valid;
    logic             commit_wen;
    reg_idx_t         commit_wdest;
    u32_t             commit_wdata;
    u32_t             commit_pc;
    logic [CNT_W-1:0] retired_count;

    integer  seed;
    string   cur_test;
    commit_t exp_q[$];
    u32_t    shadow [32];
    int      err_count;
    int      check_count;
    int      test_err_start;
    int      tests_run;
    int      tests_failed;
    int      push_count;
    int      model_count;
    logic    prev_retire_rdy;

    tb_clock_gen clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    backend_top #(
        .CNT_W (CNT_W)
    ) uut (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Byte or half picked by the address offset, then extended.
    function automatic u32_t load_value(input logic [1:0] sz, input logic uns,
                                        input u32_t addr, input u32_t rdata);
        u32_t sh;
        sh = rdata >> {addr[1:0], 3'b000};
        case (sz)
            2'd0:    load_value = {{24{~uns & sh[7]}}, sh[7:0]};
            2'd1:    load_value = {{16{~uns & sh[15]}}, sh[15:0]};
            default: load_value = rdata;
        endcase
    endfunction

    function automatic commit_t expected_commit();
        commit_t c;
        c.pc   = pc_in;
        c.dest = rd_in;
        c.wen  = is_wr_rd && rd_in != 5'd0;
        if (is_wr_rd_pc_plus4) begin
            c.data = pc_in + 32'd4;
        end else if (is_ld) begin
            c.data = load_value(ld_size, ld_unsigned, ex_out, mem_rdata);
        end else begin
            c.data = ex_out;
        end
        return c;
    endfunction

    task automatic compare_value(input string name, input u32_t expected, input u32_t actual);
        check_count++;
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic fail_on_timeout(input string what);
        $display("Timeout in %s: %s", cur_test, what);
        $display("Simulation failed");
        $finish;
    endtask

    // Sampled mid-cycle, where inputs and outputs are settled.
    always @(negedge clk) begin : commit_model
        commit_t c;
        if (rst_n) begin
            if (commit_valid && !prev_retire_rdy) begin
                $display("Error in %s: commit while the trace consumer was stalled", cur_test);
                err_count++;
            end
            if (commit_valid && exp_q.size() == 0) begin
                $display("Error in %s: unexpected commit of pc %h", cur_test, commit_pc);
                err_count++;
            end else if (commit_valid) begin
                c = exp_q.pop_front();
                compare_value({cur_test, " pc"}, c.pc, commit_pc);
                compare_value({cur_test, " wdest"}, u32_t'(c.dest), u32_t'(commit_wdest));
                compare_value({cur_test, " wen"}, u32_t'(c.wen), u32_t'(commit_wen));
                compare_value({cur_test, " wdata"}, c.data, commit_wdata);
                if (c.wen) begin
                    shadow[c.dest] = c.data;
                end
                model_count++;
            end
            // Both stages are full only when two items are in flight.
            compare_value({cur_test, " rdy_in"},
                          u32_t'(flush || retire_rdy || exp_q.size() < 2), u32_t'(rdy_in));
            // A flush also kills the item offered in the same cycle.
            if (flush) begin
                exp_q.delete();
            end else if (valid_in && rdy_in) begin
                exp_q.push_back(expected_commit());
                push_count++;
            end
            prev_retire_rdy = retire_rdy;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic make_instr(input bit load);
        logic [31:0] r;
        logic [1:0]  sz;
        r                 = $random(seed);
        sz                = (r[7:6] == 2'd3) ? 2'd2 : r[7:6];
        pc_in             = $random(seed) & 32'hffff_fffc;
        ex_out            = $random(seed);
        mem_rdata         = $random(seed);
        rd_in             = r[12:8];
        is_ld             = load;
        ld_unsigned       = r[5];
        ld_size           = ld_size_t'(sz);
        is_wr_rd          = load || r[1:0] != 2'd0;
        is_wr_rd_pc_plus4 = !load && r[4:2] == 3'd0;
        // Loads are naturally aligned.
        if (load && sz == 2'd1) begin
            ex_out[0] = 1'b0;
        end
        if (load && sz == 2'd2) begin
            ex_out[1:0] = 2'b00;
        end
    endtask

    // load_mode 0 is ALU only, 1 is loads only, 2 is mixed.
    task automatic run_traffic(input int cycles, input int load_mode, input bit stall,
                               input bit flushes, input bit r0_only);
        logic [31:0] r;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
            r          = $random(seed);
            valid_in   = !stall || r[1:0] != 2'd0;
            retire_rdy = !stall || r[2];
            flush      = flushes && r[6:3] == 4'd0;
            make_instr(load_mode == 1 || (load_mode == 2 && r[7]));
            if (r0_only) begin
                rd_in    = '0;
                is_wr_rd = 1'b1;
            end
        end
    endtask

    task automatic check_registers();
        for (int i = 0; i < 32; i += 2) begin
            @(posedge clk);
            #1;
            ridx_a = reg_idx_t'(i);
            ridx_b = reg_idx_t'(i + 1);
            @(negedge clk);
            compare_value($sformatf("%s r%0d", cur_test, i), (i == 0) ? 32'd0 : shadow[i],
                          rdata_a);
            compare_value($sformatf("%s r%0d", cur_test, i + 1), shadow[i + 1], rdata_b);
        end
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = err_count;
    endtask

    task automatic finish_test();
        tests_run++;
        if (err_count != test_err_start) begin
            tests_failed++;
        end
        $display("Test %s finished with %0d errors", cur_test, err_count - test_err_start);
    endtask

    // Drain the pipeline, then compare the counter and the register file.
    task automatic end_phase();
        int waited;
        @(posedge clk);
        #1;
        valid_in   = 1'b0;
        flush      = 1'b0;
        retire_rdy = 1'b1;
        waited     = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 50) begin
                fail_on_timeout("pipeline did not drain");
            end
        end
        repeat (2) @(negedge clk);
        compare_value({cur_test, " retired_count"}, u32_t'(model_count), retired_count);
        check_registers();
    endtask

    initial begin : main_seq
        int   pushes0;
        u32_t count0;
        int   waited;
        flush             = 1'b0;
        valid_in          = 1'b0;
        retire_rdy        = 1'b1;
        is_ld             = 1'b0;
        ld_unsigned       = 1'b0;
        is_wr_rd          = 1'b0;
        is_wr_rd_pc_plus4 = 1'b0;
        ld_size           = LD_BYTE;
        pc_in             = '0;
        ex_out            = '0;
        mem_rdata         = '0;
        rd_in             = '0;
        ridx_a            = '0;
        ridx_b            = '0;
        seed              = 32'hd221;
        prev_retire_rdy   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end

        start_test("reset_state");
        waited = 0;
        while (!rst_n) begin
            @(posedge clk);
            waited++;
            if (waited > 10) begin
                fail_on_timeout("reset was never released");
            end
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            ridx_a = reg_idx_t'($random(seed));
            ridx_b = reg_idx_t'($random(seed));
            @(negedge clk);
            compare_value("reset_state rdata_a", 32'd0, rdata_a);
            compare_value("reset_state rdata_b", 32'd0, rdata_b);
            compare_value("reset_state commit_valid", 32'd0, u32_t'(commit_valid));
            compare_value("reset_state retired_count", 32'd0, retired_count);
        end
        finish_test();

        start_test("full_rate");
        pushes0 = push_count;
        count0  = retired_count;
        run_traffic(200, 0, 1'b0, 1'b0, 1'b0);
        end_phase();
        compare_value("full_rate issued", u32_t'(push_count - pushes0), retired_count - count0);
        finish_test();

        start_test("loads");
        run_traffic(200, 1, 1'b0, 1'b0, 1'b0);
        end_phase();
        finish_test();

        start_test("back_pressure");
        run_traffic(300, 2, 1'b1, 1'b0, 1'b0);
        end_phase();
        finish_test();

        start_test("flush");
        run_traffic(300, 2, 1'b0, 1'b1, 1'b0);
        end_phase();
        finish_test();

        start_test("r0_writes");
        run_traffic(60, 2, 1'b0, 1'b0, 1'b1);
        end_phase();
        finish_test();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
hdl/cpu_pkg.sv
hdl/mem2_stage.sv
hdl/writeback_stage.sv
hdl/reg_file.sv
hdl/commit_trace.sv
hdl/backend_top.sv
sim/tb_clock_gen.sv
sim/tb_backend.sv

// File: Bender.yml
package:
  name: backend

sources:
  - hdl/cpu_pkg.sv
  - hdl/mem2_stage.sv
  - hdl/writeback_stage.sv
  - hdl/reg_file.sv
  - hdl/commit_trace.sv
  - hdl/backend_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_backend.sv
